/* verilog/micro_ctrl_defs.svh */
// ************************************************************
// widths and microword field positions for the microprogrammed
// controller: address, control store, microword, return stack
// ************************************************************
`ifndef MICRO_CTRL_DEFS_SVH
`define MICRO_CTRL_DEFS_SVH

`define ADDR_W      12      // microaddress width, as on the 2910
`define CS_AW       8       // control store address bits actually decoded
`define UWORD_W     32      // microword width
`define CTL_W       10      // datapath control outputs
`define FLAG_W      4       // external status flags
`define STACK_DEPTH 5       // return stack entries

// microword fields, top bit down
`define INSTR_HI    31
`define INSTR_LO    28
`define CCEN_BIT    27      // low enables the condition test
`define CSEL_HI     26
`define CSEL_LO     25
`define CPOL_BIT    24      // flag value that counts as a pass
`define RLD_BIT     23      // low forces a counter load
`define CI_BIT      22      // carry into the incrementer
`define BR_HI       21
`define BR_LO       10
`define CTL_HI      9
`define CTL_LO      0

`endif

/* verilog/micro_ctrl_pkg.sv */
// ************************************************************
// shared types of the microprogrammed controller
// microaddress, microword, control group, flags and the
// sixteen 2910 sequencer instructions
// ************************************************************
`include "micro_ctrl_defs.svh"

package micro_ctrl_pkg;

    typedef logic [`ADDR_W-1:0]  uaddr_t;   // also counter and stack entries
    typedef logic [`UWORD_W-1:0] uword_t;
    typedef logic [`CTL_W-1:0]   ctl_t;
    typedef logic [`FLAG_W-1:0]  flags_t;

    // instruction codes in 2910 order
    typedef enum logic [3:0] {
        JZ   = 4'd0,    // jump zero, clears stack
        CJS  = 4'd1,    // conditional jump to subroutine
        JMAP = 4'd2,    // jump to map address
        CJP  = 4'd3,    // conditional jump pipeline
        PUSH = 4'd4,    // push, conditional counter load
        JSRP = 4'd5,    // conditional subroutine, counter or pipeline
        CJV  = 4'd6,    // conditional jump vector
        JRP  = 4'd7,    // conditional jump counter or pipeline
        RFCT = 4'd8,    // repeat loop while counter nonzero
        RPCT = 4'd9,    // repeat pipeline while counter nonzero
        CRTN = 4'd10,   // conditional return
        CJPP = 4'd11,   // conditional jump pipeline and pop
        LDCT = 4'd12,   // load counter and continue
        LOOP = 4'd13,   // test end of loop
        CONT = 4'd14,   // continue
        TWB  = 4'd15    // three way branch
    } seq_op_t;

endpackage

/* verilog/seq_if.sv */
// ************************************************************
// link between the microword pipeline and the 2910 sequencer
// ************************************************************
`timescale 1ns/10ps

interface seq_if
    import micro_ctrl_pkg::*;
();

    // pipeline to sequencer
    seq_op_t instr;     // instruction field
    logic    ccen_n;    // condition enable, active low
    logic    cc_n;      // condition, low means pass
    logic    rld_n;     // counter load, active low
    logic    ci;        // incrementer carry
    uaddr_t  d;         // direct address input

    // sequencer to pipeline
    uaddr_t  y;         // next microaddress
    logic    pl_n;      // take d from the branch field
    logic    map_n;     // take d from the map address
    logic    vect_n;    // take d from the vector address

    modport seq (
        input  instr, ccen_n, cc_n, rld_n, ci, d,
        output y, pl_n, map_n, vect_n
    );

    modport pipe (
        output instr, ccen_n, cc_n, rld_n, ci, d,
        input  y, pl_n, map_n, vect_n
    );

endinterface

/* verilog/next_addr_seq.sv */
// ************************************************************
// 2910 style next address sequencer
// instruction decode, loop counter, microprogram counter,
// five entry return stack and the y multiplexer
// ************************************************************
`timescale 1ns/10ps
`include "micro_ctrl_defs.svh"

module next_addr_seq
    import micro_ctrl_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    seq_if.seq   sif,
    output logic stack_full
);

    localparam int SP_W = $clog2(`STACK_DEPTH + 1);    // pointer runs 0..depth

    uaddr_t          cnt;                       // loop / iteration counter
    uaddr_t          upc;                       // microprogram counter
    uaddr_t          stack [`STACK_DEPTH];      // entry i holds level i+1
    logic [SP_W-1:0] sp;                        // 0 means empty
    logic [SP_W-1:0] wr_idx;
    uaddr_t          stk_top;

    logic fail;
    logic pass;
    logic r_nz;
    logic full;

    // decoded terms of the 2910 table
    logic sel_r;
    logic sel_d;
    logic sel_pc;
    logic sel_stk;
    logic push;
    logic pop;
    logic load;
    logic decr;
    logic clear;

    assign fail = sif.cc_n & ~sif.ccen_n;       // a disabled test always passes
    assign pass = ~fail;
    assign r_nz = |cnt;
    assign full = (sp == SP_W'(`STACK_DEPTH));

    // empty stack reads back as the microprogram counter, so a return
    // from an empty stack just falls through
    assign stk_top = (sp == '0) ? upc : stack[sp - 1'b1];

    // a push at full overwrites the top entry
    assign wr_idx = full ? SP_W'(`STACK_DEPTH - 1) : sp;

    always_comb begin
        sel_r   = 1'b0;
        sel_d   = 1'b0;
        sel_pc  = 1'b0;
        sel_stk = 1'b0;
        push    = 1'b0;
        pop     = 1'b0;
        load    = 1'b0;
        decr    = 1'b0;
        clear   = 1'b0;
        case (sif.instr)
            JZ:   clear = 1'b1;                 // y falls to zero below
            CJS: begin
                sel_d  = pass;
                sel_pc = fail;
                push   = pass;
            end
            JMAP: sel_d = 1'b1;
            CJP, CJV: begin
                sel_d  = pass;
                sel_pc = fail;
            end
            PUSH: begin
                sel_pc = 1'b1;
                push   = 1'b1;
                load   = pass;                  // conditional counter load
            end
            JSRP: begin
                sel_d = pass;
                sel_r = fail;
                push  = 1'b1;
            end
            JRP: begin
                sel_d = pass;
                sel_r = fail;
            end
            RFCT: begin
                sel_stk = r_nz;                 // back to loop start
                decr    = r_nz;
                sel_pc  = ~r_nz;
                pop     = ~r_nz;                // loop done, drop the entry
            end
            RPCT: begin
                sel_d  = r_nz;
                decr   = r_nz;
                sel_pc = ~r_nz;
            end
            CRTN: begin
                sel_stk = pass;
                pop     = pass;
                sel_pc  = fail;
            end
            CJPP: begin
                sel_d  = pass;
                pop    = pass;
                sel_pc = fail;
            end
            LDCT: begin
                sel_pc = 1'b1;
                load   = 1'b1;
            end
            LOOP: begin
                sel_pc  = pass;
                pop     = pass;
                sel_stk = fail;
            end
            CONT: sel_pc = 1'b1;
            TWB: begin
                if (pass) begin
                    sel_pc = 1'b1;
                    pop    = 1'b1;
                    decr   = r_nz;
                end else if (r_nz) begin
                    sel_stk = 1'b1;
                    decr    = 1'b1;
                end else begin
                    sel_d = 1'b1;               // counter ran out
                    pop   = 1'b1;
                end
            end
            default: sel_pc = 1'b1;
        endcase
    end

    // next address source
    always_comb begin
        if (sel_r)
            sif.y = cnt;
        else if (sel_d)
            sif.y = sif.d;
        else if (sel_pc)
            sif.y = upc;
        else if (sel_stk)
            sif.y = stk_top;
        else
            sif.y = '0;                         // JZ
    end

    // direct address source enables, all active low
    assign sif.pl_n   = (sif.instr == JMAP) || (sif.instr == CJV);
    assign sif.map_n  = (sif.instr != JMAP);
    assign sif.vect_n = (sif.instr != CJV);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;
            upc <= '0;
            sp  <= '0;
        end else begin
            if (load || !sif.rld_n)
                cnt <= sif.d;
            else if (decr)
                cnt <= cnt - 1'b1;

            if (clear)
                upc <= '0;
            else
                upc <= sif.y + uaddr_t'(sif.ci);   // incrementer

            if (pop && sp != '0)
                sp <= sp - 1'b1;
            else if (push && !full)
                sp <= sp + 1'b1;
            else if (clear)
                sp <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            stack[wr_idx] <= upc;   // return address is the current upc
    end

    assign stack_full = full;

endmodule

/* verilog/control_store.sv */
// ************************************************************
// writable control store
// synchronous write port for the loader, combinational read
// ************************************************************
`timescale 1ns/10ps
`include "micro_ctrl_defs.svh"

module control_store
    import micro_ctrl_pkg::*;
#(
    parameter int AW = `CS_AW       // words = 2**AW
) (
    input  logic          clk,
    input  logic          we,
    input  logic [AW-1:0] waddr,
    input  uword_t        wdata,
    input  logic [AW-1:0] raddr,
    output uword_t        rdata
);

    localparam int DEPTH = 1 << AW;

    uword_t mem [DEPTH];            // microprogram

    // loader writes land at the edge, any time
    always_ff @(posedge clk) begin
        if (we)
            mem[waddr] <= wdata;
    end

    // read feeds the pipeline register in the same cycle
    assign rdata = mem[raddr];

endmodule

/* verilog/uword_pipe.sv */
// ************************************************************
// microword pipeline register
// field split, condition select and polarity, and the
// direct address source for the sequencer
// ************************************************************
`timescale 1ns/10ps
`include "micro_ctrl_defs.svh"

module uword_pipe
    import micro_ctrl_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    seq_if.pipe               sif,
    input  flags_t            flags,
    input  uaddr_t            map_addr,
    input  uaddr_t            vect_addr,
    output logic [`CS_AW-1:0] cs_raddr,
    input  uword_t            cs_rdata,
    output ctl_t              ctl
);

    uword_t      pipe_q;            // current microword
    logic [1:0]  cond_sel;
    logic        cond_pol;
    uaddr_t      br;

    // fetch address is the sequencer output with the upper bits not decoded
    assign cs_raddr = sif.y[`CS_AW-1:0];

    // all zeros after reset decodes as JZ with quiet controls
    always_ff @(posedge clk) begin
        if (!rst_n)
            pipe_q <= '0;
        else
            pipe_q <= cs_rdata;
    end

    // field split
    assign sif.instr  = seq_op_t'(pipe_q[`INSTR_HI:`INSTR_LO]);
    assign sif.ccen_n = pipe_q[`CCEN_BIT];
    assign cond_sel   = pipe_q[`CSEL_HI:`CSEL_LO];
    assign cond_pol   = pipe_q[`CPOL_BIT];
    assign sif.rld_n  = pipe_q[`RLD_BIT];
    assign sif.ci     = pipe_q[`CI_BIT];
    assign br         = pipe_q[`BR_HI:`BR_LO];
    assign ctl        = pipe_q[`CTL_HI:`CTL_LO];

    // pass (cc_n low) when the chosen flag matches the polarity bit
    assign sif.cc_n = (flags[cond_sel] != cond_pol);

    // direct address source as enabled by the sequencer decode
    always_comb begin
        if (!sif.pl_n)
            sif.d = br;
        else if (!sif.map_n)
            sif.d = map_addr;       // mapping PROM output
        else if (!sif.vect_n)
            sif.d = vect_addr;      // interrupt vector
        else
            sif.d = '0;             // no source enabled
    end

endmodule

/* verilog/micro_ctrl.sv */
// ************************************************************
// microprogrammed controller top level
// sequencer, writable control store and microword pipeline
// ************************************************************
`timescale 1ns/10ps
`include "micro_ctrl_defs.svh"

module micro_ctrl
    import micro_ctrl_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              prog_we,      // control store loader
    input  logic [`CS_AW-1:0] prog_addr,
    input  uword_t            prog_data,
    input  flags_t            flags,        // status flags for the condition mux
    input  uaddr_t            map_addr,
    input  uaddr_t            vect_addr,
    output uaddr_t            upc_addr,     // next microaddress
    output ctl_t              ctl,
    output logic              stack_full
);

    logic [`CS_AW-1:0] cs_raddr;
    uword_t            cs_rdata;

    seq_if u_seq_if ();

    next_addr_seq u_next_addr_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .sif        (u_seq_if.seq),
        .stack_full (stack_full)
    );

    control_store #(
        .AW (`CS_AW)
    ) u_control_store (
        .clk   (clk),
        .we    (prog_we),
        .waddr (prog_addr),
        .wdata (prog_data),
        .raddr (cs_raddr),
        .rdata (cs_rdata)
    );

    uword_pipe u_uword_pipe (
        .clk       (clk),
        .rst_n     (rst_n),
        .sif       (u_seq_if.pipe),
        .flags     (flags),
        .map_addr  (map_addr),
        .vect_addr (vect_addr),
        .cs_raddr  (cs_raddr),
        .cs_rdata  (cs_rdata),
        .ctl       (ctl)
    );

    assign upc_addr = u_seq_if.y;

endmodule

/* tests/micro_ctrl_chk.sv */
// ************************************************************
// concurrent checks on the sequencer return stack
// pointer range, push at full, stack clear on JZ
// ************************************************************
`timescale 1ns/10ps
`include "micro_ctrl_defs.svh"

module micro_ctrl_chk (
    input logic                                clk,
    input logic                                rst_n,
    input logic [$clog2(`STACK_DEPTH+1)-1:0]   sp,
    input logic                                push,
    input logic                                full,
    input logic                                clear
);

    sp_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        sp <= `STACK_DEPTH)
        else $error("stack pointer beyond the stack depth");

    // overwrite of the top entry keeps the depth
    push_at_full: assert property (@(posedge clk) disable iff (!rst_n)
        push && full |=> sp == `STACK_DEPTH)
        else $error("push at full moved the stack pointer");

    jz_clears: assert property (@(posedge clk) disable iff (!rst_n)
        clear |=> sp == 0)
        else $error("JZ left the stack pointer nonzero");

endmodule

bind next_addr_seq micro_ctrl_chk u_micro_ctrl_chk (
    .clk   (clk),
    .rst_n (rst_n),
    .sp    (sp),
    .push  (push),
    .full  (full),
    .clear (clear)
);

/* tests/micro_ctrl_tb.sv */
// ************************************************************
// testbench for the microprogrammed controller
// clock, reset, program loader, 2910 reference model and the
// directed tests for sequencing, branches, stack and counter
// ************************************************************
`timescale 1ns/10ps
`include "micro_ctrl_defs.svh"

module micro_ctrl_tb
    import micro_ctrl_pkg::*;
();

    localparam int RUN_CYCLES  = 16 + 40 + 60 + 20 + 40 + 20;  // stepped cycles, all tests
    localparam int LOAD_CYCLES = 6 * (16 + 4);                  // loader and reset per test
    localparam int MAX_CYCLES  = 2 * (RUN_CYCLES + LOAD_CYCLES) + 10;

    logic              clk;
    logic              rst_n;
    logic              prog_we;
    logic [`CS_AW-1:0] prog_addr;
    uword_t            prog_data;
    flags_t            flags;
    uaddr_t            map_addr;
    uaddr_t            vect_addr;
    uaddr_t            upc_addr;
    ctl_t              ctl;
    logic              stack_full;

    uword_t prog [$];                   // microprogram of the running test
    uword_t m_word;                     // model pipeline register
    uaddr_t m_upc;                      // model microprogram counter
    uaddr_t m_cnt;                      // model loop counter
    uaddr_t m_stk [$];                  // model return stack, top at the back
    int     err_cnt [4] = '{0, 0, 0, 0};    // upc_addr, ctl, stack_full, model
    int     cycles = 0;

    micro_ctrl u_micro_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .flags      (flags),
        .map_addr   (map_addr),
        .vect_addr  (vect_addr),
        .upc_addr   (upc_addr),
        .ctl        (ctl),
        .stack_full (stack_full)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;          // 8 ns period
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    // microword with random condition select, polarity and ctl
    function automatic uword_t mk(seq_op_t op, logic ccen_n, uaddr_t br, logic ci = 1'b1);
        uword_t w;
        w = '0;
        w[`INSTR_HI:`INSTR_LO] = op;
        w[`CCEN_BIT]           = ccen_n;
        w[`CSEL_HI:`CSEL_LO]   = 2'($urandom);
        w[`CPOL_BIT]           = 1'($urandom);
        w[`RLD_BIT]            = 1'b1;      // no forced counter load
        w[`CI_BIT]             = ci;
        w[`BR_HI:`BR_LO]       = br;
        w[`CTL_HI:`CTL_LO]     = ctl_t'($urandom);
        return w;
    endfunction

    // random upper bits, low byte lands on 4..7
    function automatic uaddr_t rand_target();
        uaddr_t t;
        t = uaddr_t'($urandom);
        t[`CS_AW-1:3] = '0;
        t[2] = 1'b1;
        return t;
    endfunction

    task automatic check_val(input int idx, input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL time %0t %s: got %0h expected %0h", $time, name, got, exp);
            err_cnt[idx]++;
        end
    endtask

    // one cycle of the 2910 rules, returns y and updates the model state
    task automatic model_cycle(output uaddr_t y);
        seq_op_t op;
        logic    pass;
        uaddr_t  br;
        op   = seq_op_t'(m_word[`INSTR_HI:`INSTR_LO]);
        pass = m_word[`CCEN_BIT] || (flags[m_word[`CSEL_HI:`CSEL_LO]] == m_word[`CPOL_BIT]);
        br   = m_word[`BR_HI:`BR_LO];
        y    = m_upc;                               // fall through
        case (op)
            JZ: begin
                y = '0;
                m_stk.delete();
            end
            CJP:  if (pass) y = br;
            CJS: if (pass) begin
                y = br;
                if (m_stk.size() == `STACK_DEPTH)
                    m_stk[`STACK_DEPTH-1] = m_upc;  // overwrite top when full
                else
                    m_stk.push_back(m_upc);
            end
            JMAP: y = map_addr;
            CJV:  if (pass) y = vect_addr;
            LDCT: m_cnt = br;
            RPCT: if (m_cnt != 0) begin
                y     = br;
                m_cnt = m_cnt - 1'b1;
            end
            CRTN: if (pass && m_stk.size() != 0) y = m_stk.pop_back();
            CONT: ;
            default: begin
                $display("model has no rule for instruction %s at %0t", op.name(), $time);
                err_cnt[3]++;
            end
        endcase
        m_upc = (op == JZ) ? '0 : y + uaddr_t'(m_word[`CI_BIT]);
        if (int'(y[`CS_AW-1:0]) >= prog.size()) begin
            $display("program left its loaded range at %0t, address %0h", $time, y);
            err_cnt[3]++;
            m_word = '0;
        end else
            m_word = prog[y[`CS_AW-1:0]];
    endtask

    // writes the program while reset is held, then releases reset
    task automatic load_and_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        for (int i = 0; i < prog.size(); i++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= i[`CS_AW-1:0];
            prog_data <= prog[i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
        @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic run_prog(input int n);
        uaddr_t y;
        ctl_t   exp_ctl;
        logic   exp_full;
        load_and_reset();
        m_word = '0;                    // reset word is JZ with quiet ctl
        m_upc  = '0;
        m_cnt  = '0;
        m_stk.delete();
        repeat (n) begin
            @(negedge clk);             // outputs settled
            exp_ctl  = m_word[`CTL_HI:`CTL_LO];
            exp_full = (m_stk.size() == `STACK_DEPTH);
            model_cycle(y);
            check_val(0, "upc_addr", 32'(upc_addr), 32'(y));
            check_val(1, "ctl", 32'(ctl), 32'(exp_ctl));
            check_val(2, "stack_full", 32'(stack_full), 32'(exp_full));
            @(posedge clk);
            flags     <= flags_t'($urandom);
            map_addr  <= rand_target();
            vect_addr <= rand_target();
        end
    endtask

    task automatic test_sequence();
        prog.delete();
        for (int i = 0; i < 6; i++)
            prog.push_back(mk(CONT, 1'b1, '0));
        prog.push_back(mk(CONT, 1'b1, '0, 1'b0));  // ci clear holds the address
        prog.push_back(mk(CONT, 1'b1, '0, 1'b0));
        run_prog(16);
    endtask

    task automatic test_cond_jump();
        prog.delete();
        prog.push_back(mk(CONT, 1'b1, '0));
        prog.push_back(mk(CJP, 1'b0, 12'd3));
        prog.push_back(mk(CJP, 1'b0, 12'd0));
        prog.push_back(mk(CJP, 1'b1, 12'd1));   // test disabled, always jumps
        run_prog(40);
    endtask

    task automatic test_subroutines();
        prog.delete();
        prog.push_back(mk(CONT, 1'b1, '0));
        prog.push_back(mk(CJS, 1'b1, 12'd10));
        for (int i = 2; i < 10; i++)
            prog.push_back(mk(CJP, 1'b1, 12'd2));  // park after the last return
        for (int i = 10; i < 15; i++)
            prog.push_back(mk(CJS, 1'b1, uaddr_t'(i + 1)));    // sixth call at 14
        prog.push_back(mk(CRTN, 1'b1, '0));
        run_prog(60);
    endtask

    task automatic test_counter_loop();
        uaddr_t n;
        n = uaddr_t'(2 + $urandom % 5);
        prog.delete();
        prog.push_back(mk(CONT, 1'b1, '0));
        prog.push_back(mk(LDCT, 1'b1, n));
        prog.push_back(mk(RPCT, 1'b1, 12'd2)); // repeats itself n+1 times
        prog.push_back(mk(CJP, 1'b1, 12'd3));
        run_prog(int'(n) + 12);
    endtask

    task automatic test_map_vector();
        prog.delete();
        prog.push_back(mk(CONT, 1'b1, '0));
        prog.push_back(mk(CONT, 1'b1, '0));
        prog.push_back(mk(JMAP, 1'b1, 12'd3));
        prog.push_back(mk(CJP, 1'b1, 12'd2));
        for (int i = 4; i < 8; i++)
            prog.push_back(mk(CJV, 1'b0, 12'd1));  // br must be ignored
        prog.push_back(mk(CJP, 1'b1, 12'd2));
        run_prog(40);
    endtask

    task automatic test_jump_zero();
        prog.delete();
        prog.push_back(mk(CONT, 1'b1, '0));
        prog.push_back(mk(RPCT, 1'b1, 12'd6)); // counter zero on the first pass
        prog.push_back(mk(LDCT, 1'b1, 12'd1));
        prog.push_back(mk(CJS, 1'b1, 12'd5));
        prog.push_back(mk(CJP, 1'b1, 12'd4));
        prog.push_back(mk(JZ, 1'b1, '0));      // drops the pending return
        prog.push_back(mk(CRTN, 1'b1, '0));
        prog.push_back(mk(CJP, 1'b1, 12'd7));
        run_prog(20);
    endtask

    initial begin
        void'($urandom(32'he3546ddc));
        rst_n     = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        flags     = '0;
        map_addr  = '0;
        vect_addr = '0;
        repeat (2) @(posedge clk);
        test_sequence();
        test_cond_jump();
        test_subroutines();
        test_counter_loop();
        test_map_vector();
        test_jump_zero();
        $display("errors: upc_addr %0d, ctl %0d, stack_full %0d, model %0d",
                 err_cnt[0], err_cnt[1], err_cnt[2], err_cnt[3]);
        if (err_cnt.sum() == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

/* micro_ctrl.f */
+incdir+verilog
verilog/micro_ctrl_pkg.sv
verilog/seq_if.sv
verilog/next_addr_seq.sv
verilog/control_store.sv
verilog/uword_pipe.sv
verilog/micro_ctrl.sv
tests/micro_ctrl_chk.sv
tests/micro_ctrl_tb.sv
